// ==== Makefile ====
# Verilator build for the kotku boot path

VERILATOR ?= verilator
TOP       ?= test_kotku
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LINTFLAGS ?= --lint-only --timing
SIMFLAGS  ?= --binary --timing --assert -Wno-fatal
EXE       ?= V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# the binary exits non-zero on $$fatal, so make fails with it
sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(EXE)
	./$(BUILD_DIR)/$(EXE)

clean:
	rm -rf $(BUILD_DIR)

// ==== common/kotku_pkg.sv ====
// kotku boot path definitions
package kotku_pkg;

  // **************************************************
  // address types
  // **************************************************
  typedef logic [21:0] flash_addr_t;   // byte address, 4 MB flash
  typedef logic [21:0] sdram_waddr_t;  // word address, bank:row:col

  localparam int BANK_W = 2;   // top of sdram_waddr_t
  localparam int ROW_W  = 12;  // middle field
  localparam int COL_W  = 8;   // low field

  // **************************************************
  // SDRAM command word {cs_n, ras_n, cas_n, we_n}
  // **************************************************
  typedef enum logic [3:0] {
    CMD_LOAD_MODE = 4'b0000,
    CMD_REFRESH   = 4'b0001,  // auto-refresh, cke high
    CMD_PRECHARGE = 4'b0010,  // a10 selects all banks
    CMD_ACTIVE    = 4'b0011,  // open row
    CMD_WRITE     = 4'b0100,  // a10 gives auto-precharge
    CMD_NOP       = 4'b0111,
    CMD_DESELECT  = 4'b1111   // cs_n high, rest don't care
  } sdram_cmd_t;

  // mode register
  // a9 single write, a6:4 cas 2, a3 sequential, a2:0 burst 1
  localparam logic [11:0] SDRAM_MODE = 12'b0010_0010_0000;

  // **************************************************
  // timing in clk_50 cycles
  // **************************************************
  localparam int T_RCD = 2;  // active to write
  localparam int T_RP  = 2;  // precharge to next command
  localparam int T_WR  = 2;  // write recovery
  localparam int T_RFC = 4;  // refresh to next command

  // copy length counter, holds up to 256 words
  localparam int COPY_CNT_W = 9;

endpackage

// ==== compile.f ====
common/kotku_pkg.sv
flash/flash_rd.sv
sdram/sdram_ctrl.sv
design/boot_copy.sv
design/kotku.sv
sim/flash_model.sv
sim/sdram_model.sv
sim/test_kotku.sv

// ==== design/boot_copy.sv ====
// flash to SDRAM word copier
module boot_copy (
  input  logic                     clk_50,
  input  logic                     rst_n,
  input  logic                     init_done,
  input  logic [9:0]               sw,         // sw[7:0]+1 words
  output logic                     rd_start,
  output kotku_pkg::flash_addr_t   rd_addr,
  input  logic                     rd_valid,
  input  logic [7:0]               rd_data,
  output logic                     wr_req,
  output kotku_pkg::sdram_waddr_t  wr_addr,
  output logic [15:0]              wr_data,
  input  logic                     wr_done,
  output logic [9:0]               ledr,       // byte checksum
  output logic [1:0]               ledg        // {init, copy} done
);
  import kotku_pkg::*;

  typedef enum logic [2:0] {
    ST_INIT,     // wait for sdram ready
    ST_RD_LO,
    ST_WAIT_LO,
    ST_RD_HI,
    ST_WAIT_HI,
    ST_WRITE,    // wr_req high
    ST_DONE
  } state_t;

  state_t                state_q;
  logic [COPY_CNT_W-1:0] cnt_q;   // sampled word count
  logic [COPY_CNT_W-1:0] word_q;  // current word index
  logic [15:0]           pair_q;  // {hi, lo} byte pair
  logic [9:0]            csum_q;
  logic                  done_q;

  assign rd_start = (state_q == ST_RD_LO) || (state_q == ST_RD_HI);
  assign rd_addr  = flash_addr_t'({word_q, state_q == ST_RD_HI});  // 2i or 2i+1
  assign wr_req   = (state_q == ST_WRITE);
  assign wr_addr  = sdram_waddr_t'(word_q);
  assign wr_data  = pair_q;
  assign ledr     = csum_q;
  assign ledg     = {init_done, done_q};

  // **************************************************
  // copy sequencer
  // **************************************************
  always_ff @(posedge clk_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= ST_INIT;
      cnt_q   <= '0;
      word_q  <= '0;
      csum_q  <= '0;
      done_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_INIT:
        begin
          if (init_done)
          begin
            cnt_q   <= COPY_CNT_W'(sw[7:0]) + 1'b1;  // 1 to 256 words
            state_q <= ST_RD_LO;
          end
        end
        ST_RD_LO: state_q <= ST_WAIT_LO;  // strobe lasts one cycle
        ST_WAIT_LO:
        begin
          if (rd_valid)
          begin
            csum_q  <= csum_q + 10'(rd_data);  // wraps mod 1024
            state_q <= ST_RD_HI;
          end
        end
        ST_RD_HI: state_q <= ST_WAIT_HI;
        ST_WAIT_HI:
        begin
          if (rd_valid)
          begin
            csum_q  <= csum_q + 10'(rd_data);
            state_q <= ST_WRITE;
          end
        end
        ST_WRITE:
        begin
          if (wr_done)  // wr_req drops next cycle
          begin
            word_q <= word_q + 1'b1;
            if (word_q + 1'b1 == cnt_q)
            begin
              done_q  <= 1'b1;  // sticky until reset
              state_q <= ST_DONE;
            end
            else
              state_q <= ST_RD_LO;
          end
        end
        default: state_q <= ST_DONE;  // no restart
      endcase
    end
  end

  // byte pair assembly
  always_ff @(posedge clk_50)
  begin
    if (rd_valid && state_q == ST_WAIT_LO)
      pair_q[7:0] <= rd_data;
    if (rd_valid && state_q == ST_WAIT_HI)
      pair_q[15:8] <= rd_data;
  end

  // index stops at the sampled count
  a_word_in_range: assert property (
    @(posedge clk_50) disable iff (!rst_n)
    word_q <= cnt_q
  );

endmodule

// ==== design/kotku.sv ====
// kotku board boot top
module kotku #(
  parameter int FLASH_WAIT     = 4,    // flash access cycles
  parameter int INIT_CYCLES    = 200,  // sdram power-up wait
  parameter int REFRESH_CYCLES = 390   // sdram refresh interval
) (
  input  logic                    clk_50,
  input  logic                    rst_n,
  input  logic [9:0]              sw,
  output logic [9:0]              ledr,
  output logic [7:0]              ledg,
  // flash pins
  output kotku_pkg::flash_addr_t  flash_addr,
  input  logic [7:0]              flash_data,
  output logic                    flash_oe_n,
  // sdram pins
  output logic [11:0]             sdram_addr,
  inout  wire  [15:0]             sdram_data,
  output logic [1:0]              sdram_ba,
  output logic [1:0]              sdram_dqm,
  output logic                    sdram_ras_n,
  output logic                    sdram_cas_n,
  output logic                    sdram_we_n,
  output logic                    sdram_cs_n,
  output logic                    sdram_ce,
  output logic                    sdram_clk
);
  import kotku_pkg::*;

  // copier to flash reader
  logic         rd_start;
  flash_addr_t  rd_addr;
  logic         rd_valid;
  logic [7:0]   rd_data;
  // copier to sdram controller
  logic         wr_req;
  sdram_waddr_t wr_addr;
  logic [15:0]  wr_data;
  logic         wr_done;
  logic         init_done;
  logic [1:0]   status;  // {init, copy} done

  assign sdram_clk = clk_50;  // same edge as controller
  assign ledg      = {6'b0, status};

  // **************************************************
  // blocks
  // **************************************************
  boot_copy u_copy (
    .clk_50    (clk_50),
    .rst_n     (rst_n),
    .init_done (init_done),
    .sw        (sw),
    .rd_start  (rd_start),
    .rd_addr   (rd_addr),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .wr_req    (wr_req),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_done   (wr_done),
    .ledr      (ledr),
    .ledg      (status)
  );

  flash_rd #(
    .FLASH_WAIT (FLASH_WAIT)
  ) u_flash (
    .clk_50     (clk_50),
    .rst_n      (rst_n),
    .rd_start   (rd_start),
    .rd_addr    (rd_addr),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .flash_addr (flash_addr),
    .flash_oe_n (flash_oe_n),
    .flash_data (flash_data)
  );

  sdram_ctrl #(
    .INIT_CYCLES    (INIT_CYCLES),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) u_sdram (
    .clk_50      (clk_50),
    .rst_n       (rst_n),
    .wr_req      (wr_req),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_done     (wr_done),
    .init_done   (init_done),
    .sdram_addr  (sdram_addr),
    .sdram_ba    (sdram_ba),
    .sdram_dqm   (sdram_dqm),
    .sdram_ras_n (sdram_ras_n),
    .sdram_cas_n (sdram_cas_n),
    .sdram_we_n  (sdram_we_n),
    .sdram_cs_n  (sdram_cs_n),
    .sdram_ce    (sdram_ce),
    .sdram_data  (sdram_data)
  );

endmodule

// ==== flash/flash_rd.sv ====
// parallel flash byte reader
module flash_rd #(
  parameter int FLASH_WAIT = 4  // cycles with oe_n low before sampling
) (
  input  logic                    clk_50,
  input  logic                    rst_n,
  input  logic                    rd_start,    // one-cycle strobe
  input  kotku_pkg::flash_addr_t  rd_addr,     // valid with rd_start
  output logic                    rd_valid,    // one-cycle strobe
  output logic [7:0]              rd_data,
  output kotku_pkg::flash_addr_t  flash_addr,
  output logic                    flash_oe_n,
  input  logic [7:0]              flash_data
);

  localparam int CNT_W = $clog2(FLASH_WAIT + 1);

  logic [CNT_W-1:0] cnt_q;  // cycles left in access
  logic             busy;

  assign busy = (cnt_q != '0);

  // **************************************************
  // access timer and output enable
  // **************************************************
  always_ff @(posedge clk_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q      <= '0;
      flash_oe_n <= 1'b1;  // bus idle
      rd_valid   <= 1'b0;
    end
    else
    begin
      rd_valid <= 1'b0;  // strobe by default
      if (busy)
      begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == CNT_W'(1))
        begin
          flash_oe_n <= 1'b1;  // last access cycle, release
          rd_valid   <= 1'b1;
        end
      end
      else if (rd_start)
      begin
        cnt_q      <= CNT_W'(FLASH_WAIT);
        flash_oe_n <= 1'b0;  // enable from next cycle
      end
    end
  end

  // address and data latches
  always_ff @(posedge clk_50)
  begin
    if (!busy && rd_start)
      flash_addr <= rd_addr;  // held through access
    if (busy && cnt_q == CNT_W'(1))
      rd_data <= flash_data;  // sampled at end of access time
  end

  // copier must wait for rd_valid before the next strobe
  a_no_start_busy: assert property (
    @(posedge clk_50) disable iff (!rst_n)
    rd_start |-> !busy
  );

endmodule

// ==== sdram/sdram_ctrl.sv ====
// SDRAM init, write and refresh controller
module sdram_ctrl #(
  parameter int INIT_CYCLES    = 200,  // power-up wait, cke low
  parameter int REFRESH_CYCLES = 390   // cycles between refreshes
) (
  input  logic                     clk_50,
  input  logic                     rst_n,
  input  logic                     wr_req,     // level, held until wr_done
  input  kotku_pkg::sdram_waddr_t  wr_addr,
  input  logic [15:0]              wr_data,
  output logic                     wr_done,    // one-cycle pulse
  output logic                     init_done,  // mode register loaded
  output logic [11:0]              sdram_addr,
  output logic [1:0]               sdram_ba,
  output logic [1:0]               sdram_dqm,
  output logic                     sdram_ras_n,
  output logic                     sdram_cas_n,
  output logic                     sdram_we_n,
  output logic                     sdram_cs_n,
  output logic                     sdram_ce,
  inout  wire  [15:0]              sdram_data
);
  import kotku_pkg::*;

  localparam int TMR_W = $clog2(INIT_CYCLES + T_RFC + T_WR + T_RP);
  localparam int REF_W = $clog2(REFRESH_CYCLES);

  typedef enum logic [2:0] {
    ST_POWER,     // cke low wait
    ST_PRE_ALL,
    ST_REF_INIT,  // two init refreshes
    ST_MODE,
    ST_IDLE,
    ST_WRITE,
    ST_WAIT,      // nop gap, then ret_q
    ST_DONE
  } state_t;

  state_t           state_q;
  state_t           ret_q;         // state after the gap
  logic [TMR_W-1:0] timer_q;
  logic             ref_second_q;  // first init refresh done
  logic [REF_W-1:0] ref_cnt_q;
  logic             ref_pend_q;    // periodic refresh owed
  logic             ref_issue;
  sdram_cmd_t       cmd_q;
  logic             dq_oe_q;
  logic [15:0]      dq_q;

  assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd_q;
  assign sdram_data = dq_oe_q ? dq_q : 16'bz;
  assign wr_done    = (state_q == ST_DONE);
  assign ref_issue  = (state_q == ST_IDLE) && ref_pend_q;

  // **************************************************
  // command sequencer
  // **************************************************
  always_ff @(posedge clk_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q      <= ST_POWER;
      ret_q        <= ST_IDLE;
      timer_q      <= TMR_W'(INIT_CYCLES - 1);
      ref_second_q <= 1'b0;
      cmd_q        <= CMD_DESELECT;
      sdram_addr   <= '0;
      sdram_ba     <= '0;
      sdram_dqm    <= 2'b11;  // masked until a write
      dq_oe_q      <= 1'b0;
      sdram_ce     <= 1'b0;
      init_done    <= 1'b0;
    end
    else
    begin
      cmd_q     <= CMD_NOP;  // one-cycle commands
      sdram_dqm <= 2'b11;
      dq_oe_q   <= 1'b0;
      case (state_q)
        ST_POWER:
        begin
          cmd_q <= CMD_DESELECT;
          if (timer_q == '0)
          begin
            sdram_ce <= 1'b1;  // clock enable, then precharge
            state_q  <= ST_PRE_ALL;
          end
          else
            timer_q <= timer_q - 1'b1;
        end
        ST_PRE_ALL:
        begin
          cmd_q      <= CMD_PRECHARGE;
          sdram_addr <= 12'h400;  // a10, all banks
          timer_q    <= TMR_W'(T_RP - 2);
          ret_q      <= ST_REF_INIT;
          state_q    <= ST_WAIT;
        end
        ST_REF_INIT:
        begin
          cmd_q        <= CMD_REFRESH;
          ref_second_q <= ~ref_second_q;
          timer_q      <= TMR_W'(T_RFC - 2);
          ret_q        <= ref_second_q ? ST_MODE : ST_REF_INIT;
          state_q      <= ST_WAIT;
        end
        ST_MODE:
        begin
          cmd_q      <= CMD_LOAD_MODE;
          sdram_ba   <= '0;
          sdram_addr <= SDRAM_MODE;
          init_done  <= 1'b1;              // held until reset
          timer_q    <= TMR_W'(T_RP - 2);  // tmrd covered by t_rp
          ret_q      <= ST_IDLE;
          state_q    <= ST_WAIT;
        end
        ST_IDLE:
        begin
          if (ref_pend_q)  // refresh before any write
          begin
            cmd_q   <= CMD_REFRESH;
            timer_q <= TMR_W'(T_RFC - 2);
            ret_q   <= ST_IDLE;
            state_q <= ST_WAIT;
          end
          else if (wr_req)
          begin
            cmd_q      <= CMD_ACTIVE;
            sdram_ba   <= wr_addr[ROW_W+COL_W +: BANK_W];
            sdram_addr <= wr_addr[COL_W +: ROW_W];  // row
            timer_q    <= TMR_W'(T_RCD - 2);
            ret_q      <= ST_WRITE;
            state_q    <= ST_WAIT;
          end
        end
        ST_WRITE:
        begin
          cmd_q      <= CMD_WRITE;
          sdram_addr <= 12'(wr_addr[COL_W-1:0]) | 12'h400;  // a10 auto-precharge
          sdram_dqm  <= 2'b00;  // both bytes
          dq_oe_q    <= 1'b1;
          timer_q    <= TMR_W'(T_WR + T_RP - 2);
          ret_q      <= ST_DONE;
          state_q    <= ST_WAIT;
        end
        ST_WAIT:
        begin
          if (timer_q == '0)
            state_q <= ret_q;
          else
            timer_q <= timer_q - 1'b1;
        end
        default: state_q <= ST_IDLE;  // ST_DONE, wr_done high here
      endcase
    end
  end

  // write data latch
  always_ff @(posedge clk_50)
  begin
    if (state_q == ST_WRITE)
      dq_q <= wr_data;
  end

  // **************************************************
  // periodic refresh request
  // **************************************************
  always_ff @(posedge clk_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ref_cnt_q  <= '0;
      ref_pend_q <= 1'b0;
    end
    else if (init_done)  // starts after load-mode
    begin
      if (ref_cnt_q == REF_W'(REFRESH_CYCLES - 1))
      begin
        ref_cnt_q  <= '0;
        ref_pend_q <= 1'b1;  // set wins over clear
      end
      else
      begin
        ref_cnt_q <= ref_cnt_q + 1'b1;
        if (ref_issue)
          ref_pend_q <= 1'b0;
      end
    end
  end

  // handshake end never overlaps a refresh on the pins
  a_done_not_refresh: assert property (
    @(posedge clk_50) disable iff (!rst_n)
    !(wr_done && cmd_q == CMD_REFRESH)
  );

  // data bus owned only for the write command, unmasked
  a_dq_write_only: assert property (
    @(posedge clk_50) disable iff (!rst_n)
    dq_oe_q |-> (cmd_q == CMD_WRITE && sdram_dqm == 2'b00)
  );

endmodule

// ==== sim/flash_model.sv ====
// behavioural parallel flash
module flash_model #(
  parameter int DEPTH = 512  // modelled bytes, rest reads erased
) (
  input  kotku_pkg::flash_addr_t  addr,
  output logic [7:0]              data,
  input  logic                    oe_n,
  input  logic                    we_n,   // tied high, no programming
  input  logic                    rst_n   // tied high, device reset
);

  logic [7:0] mem [0:DEPTH-1];  // loaded by the testbench

  // **************************************************
  // read path
  // **************************************************
  // the bus floats high when the device does not drive it
  always_comb
  begin
    if (!rst_n || oe_n || !we_n)
      data = 8'hff;  // output disabled, pulled up
    else if (int'(addr) < DEPTH)
      data = mem[int'(addr)];  // asynchronous read
    else
      data = 8'hff;  // erased area
  end

endmodule

// ==== sim/sdram_model.sv ====
// behavioural write-only SDRAM
module sdram_model #(
  parameter int          REFRESH_CYCLES = 390,      // expected refresh interval
  parameter int          DEPTH          = 512,      // modelled words from address 0
  parameter logic [15:0] FILL           = 16'hdead  // marker loaded during reset
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cke,
  input  logic        cs_n,
  input  logic        ras_n,
  input  logic        cas_n,
  input  logic        we_n,
  input  logic [1:0]  ba,
  input  logic [11:0] addr,
  input  logic [1:0]  dqm,
  input  wire  [15:0] dq,
  output logic        fault,     // protocol error seen
  output int          ref_count  // refreshes after mode load
);
  import kotku_pkg::*;

  // ACTIVE to the next IDLE of the controller
  localparam int WRITE_TIME = T_RCD + T_WR + T_RP + 3;

  logic [15:0] mem [0:DEPTH-1];
  logic [3:0]  row_open;           // one flag per bank
  logic [11:0] open_row [0:3];
  logic        mode_ok;            // mode register loaded
  logic        ref_seen;           // first periodic refresh done
  int          since;              // edges since last command
  int          min_gap;            // edges the last command needs
  int          ref_gap;
  int          waddr;
  int          idx;
  sdram_cmd_t  cmd;

  assign cmd = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});

  task automatic protocol_error(input string msg);
    $display("sdram model: %s at time %0t", msg, $time);
    fault <= 1'b1;
  endtask

  // **************************************************
  // command decoder and checks
  // **************************************************
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (idx = 0; idx < DEPTH; idx++)
        mem[idx] <= FILL;
      row_open  <= '0;
      mode_ok   <= 1'b0;
      ref_seen  <= 1'b0;
      since     <= 0;
      min_gap   <= 0;
      ref_gap   <= 0;
      ref_count <= 0;
      fault     <= 1'b0;
    end
    else
    begin
      since <= since + 1;
      if (ref_seen)
        ref_gap <= ref_gap + 1;
      if (ref_seen && ref_gap > REFRESH_CYCLES + WRITE_TIME)
        protocol_error("refresh interval too long");
      if (!cke && !cs_n)
        protocol_error("command while CKE low");
      else if (cke && !cs_n && cmd != CMD_NOP)
      begin
        since <= 1;
        if (since < min_gap)
          protocol_error("command inside tRCD, tRP or tRFC");
        case (cmd)
          CMD_LOAD_MODE:
          begin
            if (addr != SDRAM_MODE)
              protocol_error("wrong mode register value");
            if (row_open != '0)
              protocol_error("mode load with a bank open");
            mode_ok <= 1'b1;
            min_gap <= T_RP;  // tmrd
          end
          CMD_REFRESH:
          begin
            if (row_open != '0)
              protocol_error("refresh with a bank open");
            min_gap <= T_RFC;
            if (mode_ok)  // init refreshes not counted
            begin
              ref_count <= ref_count + 1;
              ref_seen  <= 1'b1;
              ref_gap   <= 1;
            end
          end
          CMD_PRECHARGE:
          begin
            if (addr[10])
              row_open <= '0;  // all banks
            else
              row_open[ba] <= 1'b0;
            min_gap <= T_RP;
          end
          CMD_ACTIVE:
          begin
            if (!mode_ok)
              protocol_error("ACTIVE before mode register load");
            if (row_open[ba])
              protocol_error("ACTIVE to a bank with an open row");
            row_open[ba] <= 1'b1;
            open_row[ba] <= addr;
            min_gap      <= T_RCD;
          end
          CMD_WRITE:
          begin
            if (!mode_ok)
              protocol_error("WRITE before mode register load");
            if (!row_open[ba])
              protocol_error("WRITE to a bank without an open row");
            else
            begin
              waddr = int'({ba, open_row[ba], addr[7:0]});
              if (waddr >= DEPTH)
                protocol_error("WRITE outside the modelled range");
              else
              begin
                if (!dqm[0])
                  mem[waddr][7:0] <= dq[7:0];
                if (!dqm[1])
                  mem[waddr][15:8] <= dq[15:8];
              end
            end
            if (addr[10])
              row_open[ba] <= 1'b0;  // auto-precharge
            min_gap <= T_WR + T_RP;
          end
          default: protocol_error("unsupported command");
        endcase
      end
    end
  end

endmodule

// ==== sim/test_kotku.sv ====
// kotku boot path testbench
module test_kotku;
  import kotku_pkg::*;

  localparam int FLASH_WAIT     = 4;
  localparam int INIT_CYCLES    = 200;
  localparam int REFRESH_CYCLES = 390;
  localparam int IMAGE_BYTES    = 512;
  localparam int SDRAM_WORDS    = 512;
  localparam int N_TESTS        = 5;
  localparam int INIT_TIMEOUT   = 1000;   // cycles to init done
  localparam int COPY_TIMEOUT   = 20000;  // cycles to copy done

  // **************************************************
  // stimulus table of switch values and word counts
  // **************************************************
  localparam logic [9:0] SW_TAB [N_TESTS] = '{10'd0, 10'd1, 10'd7, 10'd40, 10'd255};
  localparam int WORDS_TAB [N_TESTS] = '{1, 2, 8, 41, 256};

  logic        clk_50;
  logic        rst_n;
  logic [9:0]  sw;
  logic [9:0]  ledr;
  logic [7:0]  ledg;
  flash_addr_t flash_addr;
  logic [7:0]  flash_data;
  logic        flash_oe_n;
  logic [11:0] sdram_addr;
  wire  [15:0] sdram_data;
  logic [1:0]  sdram_ba;
  logic [1:0]  sdram_dqm;
  logic        sdram_ras_n;
  logic        sdram_cas_n;
  logic        sdram_we_n;
  logic        sdram_cs_n;
  logic        sdram_ce;
  logic        sdram_clk;
  logic        mem_fault;
  int          ref_count;
  logic [7:0]  image [0:IMAGE_BYTES-1];  // expected flash contents
  logic [15:0] lfsr_q;

  initial clk_50 = 1'b0;
  always #2 clk_50 = ~clk_50;

  kotku #(
    .FLASH_WAIT     (FLASH_WAIT),
    .INIT_CYCLES    (INIT_CYCLES),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) u_dut (
    .clk_50 (clk_50), .rst_n (rst_n), .sw (sw), .ledr (ledr), .ledg (ledg),
    .flash_addr (flash_addr), .flash_data (flash_data), .flash_oe_n (flash_oe_n),
    .sdram_addr (sdram_addr), .sdram_data (sdram_data), .sdram_ba (sdram_ba),
    .sdram_dqm (sdram_dqm), .sdram_ras_n (sdram_ras_n), .sdram_cas_n (sdram_cas_n),
    .sdram_we_n (sdram_we_n), .sdram_cs_n (sdram_cs_n), .sdram_ce (sdram_ce),
    .sdram_clk (sdram_clk)
  );

  flash_model #(.DEPTH (IMAGE_BYTES)) u_flash_mem (
    .addr (flash_addr), .data (flash_data), .oe_n (flash_oe_n),
    .we_n (1'b1), .rst_n (1'b1)  // no programming
  );

  sdram_model #(.REFRESH_CYCLES (REFRESH_CYCLES), .DEPTH (SDRAM_WORDS)) u_sdram_mem (
    .clk (sdram_clk), .rst_n (rst_n), .cke (sdram_ce), .cs_n (sdram_cs_n),
    .ras_n (sdram_ras_n), .cas_n (sdram_cas_n), .we_n (sdram_we_n), .ba (sdram_ba),
    .addr (sdram_addr), .dqm (sdram_dqm), .dq (sdram_data), .fault (mem_fault),
    .ref_count (ref_count)
  );

  // fibonacci taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic stop_with_fail(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp)
      stop_with_fail($sformatf("** Error at time %0t: %s, got 0x%0h, expected 0x%0h",
                               $time, what, got, exp));
  endtask

  task automatic load_flash_image();
    logic [7:0] b;
    int         a;
    int         k;
    lfsr_q = 16'd91;
    for (a = 0; a < IMAGE_BYTES; a++)
    begin
      for (k = 0; k < 8; k++)
      begin
        lfsr_q = lfsr_next(lfsr_q);  // one step per bit
        b[k]   = lfsr_q[0];
      end
      image[a]           = b;
      u_flash_mem.mem[a] = b;
    end
  endtask

  // 3-cycle reset with idle outputs checked inside
  task automatic apply_reset();
    @(negedge clk_50);
    rst_n = 1'b0;
    repeat (3) @(negedge clk_50);
    check_value(ledg, 8'h00, "ledg in reset");
    check_value(ledr, 10'h000, "ledr in reset");
    check_value(sdram_ce, 1'b0, "sdram_ce in reset");
    check_value(flash_oe_n, 1'b1, "flash_oe_n in reset");
    check_value({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n}, CMD_DESELECT,
                "sdram command in reset");
    check_value(sdram_dqm, 2'b11, "sdram_dqm in reset");
    rst_n = 1'b1;
  endtask

  task automatic wait_led(input int bit_idx, input int limit, input string what);
    int cnt;
    cnt = 0;
    while (!ledg[bit_idx])
    begin
      @(negedge clk_50);
      cnt++;
      if (cnt > limit)
        stop_with_fail($sformatf("timeout: %s did not rise within %0d cycles", what, limit));
    end
  endtask

  // protocol errors from the SDRAM model
  always @(negedge clk_50)
  begin
    if (mem_fault)
      stop_with_fail("SDRAM model saw a protocol error");
  end

  // **************************************************
  // table loop
  // **************************************************
  initial
  begin
    int          t;
    int          i;
    int          n;
    int          csum;
    logic [15:0] exp_word;
    rst_n = 1'b0;
    sw    = '0;
    load_flash_image();
    for (t = 0; t < N_TESTS; t++)
    begin
      @(negedge clk_50);
      sw = SW_TAB[t];
      apply_reset();  // model refills its array here
      wait_led(1, INIT_TIMEOUT, "init done on ledg[1]");
      check_value(ledg[0], 1'b0, "copy done before init done");
      wait_led(0, COPY_TIMEOUT, "copy done on ledg[0]");
      n    = WORDS_TAB[t];
      csum = 0;
      for (i = 0; i < SDRAM_WORDS; i++)
      begin
        exp_word = (i < n) ? {image[2*i+1], image[2*i]} : 16'hdead;
        check_value(u_sdram_mem.mem[i], exp_word, $sformatf("sdram word %0d", i));
      end
      for (i = 0; i < 2 * n; i++)
        csum = (csum + image[i]) % 1024;
      check_value(ledr, csum, "checksum on ledr");
      check_value(ledg, 8'h03, "green leds after copy");
      if (n == 256)
        check_value(ref_count > 0, 1'b1, "periodic refresh during long copy");
    end
    if (mem_fault)
      stop_with_fail("SDRAM model saw a protocol error");
    else
    begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule
